// ==== source/uart_cfg_pkg.sv ====
package uart_cfg_pkg;

  // clk cycles between two oversample ticks
  // at 100 MHz this is far above any real baud rate, which keeps simulation short
  localparam int CLKS_PER_TICK = 4;

  // ticks per serial bit, the receiver samples at the centre of this window
  localparam int OVERSAMPLE = 16;

  // payload width of one 8N1 frame
  localparam int DATA_BITS = 8;

  // length of one bit on the line in clk cycles
  localparam int CLKS_PER_BIT = CLKS_PER_TICK * OVERSAMPLE;

  // tick inside the start bit where the receiver looks at the line again
  localparam int MID_SAMPLE = OVERSAMPLE / 2;

  // counter widths, kept at one bit or more so a divide-by-one tick still builds
  localparam int TICK_CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
  localparam int OS_CNT_W   = (OVERSAMPLE > 1) ? $clog2(OVERSAMPLE) : 1;
  localparam int BIT_CNT_W  = (DATA_BITS > 1) ? $clog2(DATA_BITS) : 1;

  // terminal counts, sized to the counters that compare against them
  // the tick generator wraps here
  localparam logic [TICK_CNT_W-1:0] TICK_LAST = TICK_CNT_W'(CLKS_PER_TICK - 1);

  // last tick of a bit period, both directions move on after it
  localparam logic [OS_CNT_W-1:0] OS_LAST = OS_CNT_W'(OVERSAMPLE - 1);

  // the start-bit check happens on this tick count
  localparam logic [OS_CNT_W-1:0] MID_LAST = OS_CNT_W'(MID_SAMPLE - 1);

  // index of the final data bit, LSB goes first
  localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(DATA_BITS - 1);

endpackage

// ==== source/uart_frame_pkg.sv ====
package uart_frame_pkg;

  // request into the transmitter
  // valid is a one-cycle strobe and data is only looked at in that cycle
  // the transmitter takes it only while idle, anything sent while a frame
  // is on the line is lost without notice
  //
  // layout, msb first
  //   [8]   valid
  //   [7:0] data
  typedef struct packed {
    // strobe that asks for one frame
    logic                               valid;
    // byte to send, bit 0 leaves first
    logic [uart_cfg_pkg::DATA_BITS-1:0] data;
  } uart_tx_req_t;

  // word out of the receiver
  // valid pulses for one cycle at the middle of the stop bit
  // data and frame_err belong to that same cycle, there is no hold
  // and no back-pressure, so the consumer has to register it right away
  //
  // layout, msb first
  //   [9]   valid
  //   [8:1] data
  //   [0]   frame_err
  typedef struct packed {
    // one strobe per frame that passed the start-bit check
    logic                               valid;
    // assembled byte, first bit on the line ends up in bit 0
    logic [uart_cfg_pkg::DATA_BITS-1:0] data;
    // stop bit was seen low at its centre sample
    // the data is still handed out so software can decide what to do
    logic                               frame_err;
  } uart_rx_word_t;

  // a glitch that fails the start-bit check never shows up here at all,
  // it only costs the receiver half a bit of busy time
  // a frame with a bad stop bit does show up, with frame_err set
  // the transmitter always sends a high stop bit, so in loopback
  // frame_err can only come from a disturbed line

endpackage

// ==== source/uart_baud_gen.sv ====
`timescale 1ns/1ps

module uart_baud_gen (
  input  logic clk,
  input  logic arst_n,
  output logic os_tick
);

  // free-running divider from clk down to the oversample rate
  // both directions share it, so transmit and receive agree on bit length
  // it never stops or restarts once reset is gone, which means a new
  // transmit frame lines up with the next tick and the receiver sees up
  // to one tick of phase error against the incoming edge
  logic [uart_cfg_pkg::TICK_CNT_W-1:0] clk_cnt;

  // the terminal count is decoded once here and used for both the pulse
  // and the wrap
  logic at_last;

  assign at_last = (clk_cnt == uart_cfg_pkg::TICK_LAST);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clk_cnt <= '0;
      os_tick <= 1'b0;
    end else begin
      // the tick is registered so it is a clean one-cycle pulse
      // with no decode logic in front of the consumers
      os_tick <= at_last;

      // wrap explicitly so a divider that is not a power of two
      // still gives an exact period
      if (at_last) begin
        clk_cnt <= '0;
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  // first tick comes CLKS_PER_TICK cycles after reset release,
  // then exactly every CLKS_PER_TICK cycles after that
  // nothing here depends on what the transmitter or receiver is doing
  //
  // with the default settings this gives a tick every 4 clocks
  // and a bit time of 64 clocks
  //
  // the counter holds no state besides its phase, so if reset is
  // asserted in the middle of a frame the next frame simply starts
  // on a fresh phase
  //
  // tx and rx each count 16 of these per bit on their own, so they
  // only share the tick phase and not a bit phase
  // that matters because the receiver has to lock onto whatever edge
  // arrives on rxd, while the transmitter picks its own start
  // a slower line would only need a larger CLKS_PER_TICK

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         os_tick,
  input  uart_frame_pkg::uart_tx_req_t tx_req,
  output logic                         txd,
  output logic                         tx_done
);

  // start covers the wait for the first tick as well as the start bit itself
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  tx_state_e                          state;
  logic [uart_cfg_pkg::OS_CNT_W-1:0]  tick_cnt;
  logic [uart_cfg_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [uart_cfg_pkg::DATA_BITS-1:0] shift_q;
  logic                               bit_end;
  logic                               accept;

  // a request only counts in idle, in any other state it is dropped
  assign accept = (state == TX_IDLE) && tx_req.valid;

  // last tick of the current bit period
  assign bit_end = os_tick && (tick_cnt == uart_cfg_pkg::OS_LAST);

  // byte holder, loaded on accept and shifted right as each bit goes out
  // bit 0 always holds the next bit to put on the line
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_q <= tx_req.data;
    end else if (bit_end && ((state == TX_START) || (state == TX_DATA))) begin
      shift_q <= shift_q >> 1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= TX_IDLE;
      txd      <= 1'b1;
      tx_done  <= 1'b0;
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      // done is a strobe, so it falls back the cycle after it is set
      tx_done <= 1'b0;

      case (state)
        TX_IDLE: begin
          if (tx_req.valid) begin
            state    <= TX_START;
            tick_cnt <= '0;
          end
        end

        TX_START: begin
          if (os_tick) begin
            // txd still high means the start bit has not begun yet,
            // so this tick drops the line and the count begins on the next
            if (txd) begin
              txd <= 1'b0;
            end else if (bit_end) begin
              txd      <= shift_q[0];
              tick_cnt <= '0;
              bit_cnt  <= '0;
              state    <= TX_DATA;
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end

        TX_DATA: begin
          if (bit_end) begin
            tick_cnt <= '0;
            if (bit_cnt == uart_cfg_pkg::BIT_LAST) begin
              // stop bit is a plain high level
              txd   <= 1'b1;
              state <= TX_STOP;
            end else begin
              txd     <= shift_q[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else if (os_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end

        TX_STOP: begin
          // 640 clocks after txd fell, the frame is over
          if (bit_end) begin
            tick_cnt <= '0;
            tx_done  <= 1'b1;
            state    <= TX_IDLE;
          end else if (os_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end

        default: begin
          state <= TX_IDLE;
          txd   <= 1'b1;
        end
      endcase
    end
  end

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          os_tick,
  input  logic                          rxd,
  output uart_frame_pkg::uart_rx_word_t rx_out
);

  // start is the half-bit window where the edge gets checked
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e                          state;
  logic [uart_cfg_pkg::OS_CNT_W-1:0]  tick_cnt;
  logic [uart_cfg_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [uart_cfg_pkg::DATA_BITS-1:0] shift_q;

  // two flops for metastability, a third one to see the edge
  logic rxd_meta;
  logic rxd_sync;
  logic rxd_prev;
  logic fall;
  logic bit_end;

  // output word pieces, packed into the struct below
  logic                               word_valid;
  logic [uart_cfg_pkg::DATA_BITS-1:0] word_data;
  logic                               word_err;

  // flops come out of reset high, so an idle line gives no false edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  // only a real high to low change starts a frame
  // a line that stays low after a bad stop bit does not retrigger
  assign fall = rxd_prev && !rxd_sync;

  // centre of a data or stop bit, a full bit after the previous centre
  assign bit_end = os_tick && (tick_cnt == uart_cfg_pkg::OS_LAST);

  // data comes in LSB first, so each new bit enters at the top
  always_ff @(posedge clk) begin
    if (bit_end && (state == RX_DATA)) begin
      shift_q <= {rxd_sync, shift_q[uart_cfg_pkg::DATA_BITS-1:1]};
    end
  end

  // payload of the output word changes only at a stop-bit sample
  always_ff @(posedge clk) begin
    if (bit_end && (state == RX_STOP)) begin
      word_data <= shift_q;
      word_err  <= !rxd_sync;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= RX_IDLE;
      tick_cnt   <= '0;
      bit_cnt    <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;

      case (state)
        RX_IDLE: begin
          if (fall) begin
            state    <= RX_START;
            tick_cnt <= '0;
          end
        end

        RX_START: begin
          if (os_tick) begin
            if (tick_cnt == uart_cfg_pkg::MID_LAST) begin
              tick_cnt <= '0;
              // line back high at half a bit means a glitch, not a start bit
              if (rxd_sync) begin
                state <= RX_IDLE;
              end else begin
                bit_cnt <= '0;
                state   <= RX_DATA;
              end
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end

        RX_DATA: begin
          if (bit_end) begin
            tick_cnt <= '0;
            if (bit_cnt == uart_cfg_pkg::BIT_LAST) begin
              state <= RX_STOP;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else if (os_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end

        RX_STOP: begin
          // the word goes out here whether or not the stop bit was good
          if (bit_end) begin
            tick_cnt   <= '0;
            word_valid <= 1'b1;
            state      <= RX_IDLE;
          end else if (os_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end

        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  assign rx_out = '{valid: word_valid, data: word_data, frame_err: word_err};

endmodule

// ==== source/uart_core.sv ====
`timescale 1ns/1ps

module uart_core (
  input  logic                          clk,
  input  logic                          arst_n,
  input  uart_frame_pkg::uart_tx_req_t  tx_req,
  output logic                          tx_done,
  output logic                          txd,
  input  logic                          rxd,
  output uart_frame_pkg::uart_rx_word_t rx_out
);

  // shared oversample tick
  // both halves run off the same divider but keep their own bit phase
  logic os_tick;

  // tick source, free-running from reset release
  uart_baud_gen uart_baud_gen_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .os_tick (os_tick)
  );

  // transmit side
  // a request while a frame is going out is dropped inside the transmitter,
  // the caller should wait for tx_done before the next one
  uart_tx uart_tx_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .os_tick (os_tick),
    .tx_req  (tx_req),
    .txd     (txd),
    .tx_done (tx_done)
  );

  // receive side
  // rxd may come from anywhere, the receiver brings it into clk itself
  // glitches shorter than half a bit are filtered there too
  uart_rx uart_rx_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .os_tick (os_tick),
    .rxd     (rxd),
    .rx_out  (rx_out)
  );

  // there is no internal loopback path, tying txd to rxd is left to the
  // board or the testbench, so the two directions stay fully independent
  //
  // with loopback, a byte comes back on rx_out about nine and a half bits
  // after the start edge, which is well before tx_done for the same frame
  //
  // parity, flow control and FIFOs are not part of this core
  // a wrapper can add them around these ports without touching the
  // timing of either direction
  //
  // all three blocks share one asynchronous reset and one clock,
  // so the only clock crossing in the core is rxd into the receiver

endmodule

// ==== sim/uart_core_assert.sv ====
`timescale 1ns/1ps

module uart_core_assert (
  input logic                          clk,
  input logic                          arst_n,
  input logic                          txd,
  input logic                          tx_done,
  input uart_frame_pkg::uart_rx_word_t rx_out
);

  // counts the cycles since reset release and saturates at 16
  logic [4:0] since_reset;

  // number of assertion failures seen so far
  int unsigned fail_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      since_reset <= '0;
    end else if (since_reset != 5'd16) begin
      since_reset <= since_reset + 5'd1;
    end
  end

  // the line has to stay idle while nothing has been requested yet
  idle_after_reset: assert property (
    @(posedge clk) disable iff (!arst_n) (since_reset < 5'd16) |-> txd
  ) else begin
    fail_cnt++;
    $error("txd left the idle level within 16 cycles of reset");
  end

  // both strobes last exactly one cycle
  done_is_strobe: assert property (
    @(posedge clk) disable iff (!arst_n) tx_done |=> !tx_done
  ) else begin
    fail_cnt++;
    $error("tx_done stayed high for two cycles");
  end

  rx_valid_is_strobe: assert property (
    @(posedge clk) disable iff (!arst_n) rx_out.valid |=> !rx_out.valid
  ) else begin
    fail_cnt++;
    $error("rx_out.valid stayed high for two cycles");
  end

endmodule

// ==== sim/uart_core_tb.sv ====
`timescale 1ns/1ps

module uart_core_tb;

  // one 8N1 frame is ten bits on the line
  localparam int FRAME_CLKS = 10 * uart_cfg_pkg::CLKS_PER_BIT;
  localparam int RST_CYCLES = 8;
  localparam int IDLE_CYCLES = 20;

  // entry kinds
  // loop sends through the transmitter, drop adds a second request mid frame,
  // force drives rxd bit by bit, glitch puts a short low pulse on rxd
  localparam logic [1:0] KIND_LOOP   = 2'd0;
  localparam logic [1:0] KIND_DROP   = 2'd1;
  localparam logic [1:0] KIND_FORCE  = 2'd2;
  localparam logic [1:0] KIND_GLITCH = 2'd3;

  localparam logic [7:0] FIXED_BYTES [9] = '{
    8'h05, 8'h06, 8'h78, 8'h96, 8'hFF, 8'h35, 8'hED, 8'h96, 8'h00
  };

  typedef struct packed {
    logic [1:0]                         kind;
    logic [uart_cfg_pkg::DATA_BITS-1:0] data;
    logic                               stop;
    logic                               exp_word;
    logic [uart_cfg_pkg::DATA_BITS-1:0] exp_data;
    logic                               exp_err;
  } vec_t;

  logic                          clk;
  logic                          arst_n;
  uart_frame_pkg::uart_tx_req_t  tx_req;
  logic                          tx_done;
  logic                          txd;
  logic                          rxd;
  uart_frame_pkg::uart_rx_word_t rx_out;

  // rxd follows txd in loopback, otherwise the testbench owns the line
  logic loop_mode;
  logic force_rxd;

  uart_frame_pkg::uart_rx_word_t rx_q[$];
  vec_t vec_q[$];
  int done_cnt;
  int table_len;
  int seed;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  assign rxd = loop_mode ? txd : force_rxd;

  uart_core uart_core_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .tx_req  (tx_req),
    .tx_done (tx_done),
    .txd     (txd),
    .rxd     (rxd),
    .rx_out  (rx_out)
  );

  bind uart_core uart_core_assert uart_core_assert_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .txd     (txd),
    .tx_done (tx_done),
    .rx_out  (rx_out)
  );

  // every received word and every done strobe is collected here
  always @(posedge clk) begin
    if (rx_out.valid) begin
      rx_q.push_back(rx_out);
    end
    if (tx_done) begin
      done_cnt++;
    end
  end

  task automatic stop_with_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic void add_vec(input logic [1:0] kind, input logic [7:0] data,
                                  input logic stop, input logic exp_word,
                                  input logic exp_err);
    vec_t v;
    v.kind     = kind;
    v.data     = data;
    v.stop     = stop;
    v.exp_word = exp_word;
    // a received byte always equals the byte that went on the line
    v.exp_data = data;
    v.exp_err  = exp_err;
    vec_q.push_back(v);
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // the forced line keeps each level for the given number of clocks
  task automatic hold_line(input logic level, input int cycles);
    @(posedge clk);
    force_rxd <= level;
    repeat (cycles - 1) @(posedge clk);
  endtask

  task automatic send_request(input logic [7:0] data);
    @(posedge clk);
    tx_req <= '{valid: 1'b1, data: data};
    @(posedge clk);
    tx_req <= '0;
  endtask

  // start bit, eight data bits LSB first, then the chosen stop level
  task automatic drive_frame(input logic [7:0] data, input logic stop);
    hold_line(1'b0, uart_cfg_pkg::CLKS_PER_BIT);
    for (int i = 0; i < uart_cfg_pkg::DATA_BITS; i++) begin
      hold_line(data[i], uart_cfg_pkg::CLKS_PER_BIT);
    end
    hold_line(stop, uart_cfg_pkg::CLKS_PER_BIT);
    hold_line(1'b1, 1);
  endtask

  task automatic wait_tx_done(input int done_before);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (done_cnt == done_before && n < 2 * FRAME_CLKS);
    if (done_cnt == done_before) begin
      stop_with_error("tx_done never came after a request");
    end
  endtask

  task automatic wait_word();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (rx_q.size() == 0 && n < 2 * FRAME_CLKS);
    if (rx_q.size() == 0) begin
      stop_with_error("no word came out of the receiver");
    end
  endtask

  task automatic run_vec(input vec_t v);
    uart_frame_pkg::uart_rx_word_t w;
    int done_before;
    int done_step;
    done_before = done_cnt;
    done_step = ((v.kind == KIND_LOOP) || (v.kind == KIND_DROP)) ? 1 : 0;
    @(posedge clk);
    loop_mode <= (v.kind == KIND_LOOP) || (v.kind == KIND_DROP);
    case (v.kind)
      KIND_LOOP: begin
        send_request(v.data);
        wait_tx_done(done_before);
      end
      KIND_DROP: begin
        // the second byte arrives mid frame and has to vanish
        send_request(v.data);
        idle_cycles(100);
        send_request(~v.data);
        wait_tx_done(done_before);
        idle_cycles(FRAME_CLKS);
      end
      KIND_FORCE: begin
        drive_frame(v.data, v.stop);
      end
      default: begin
        // eight clocks is well under the half-bit start check
        hold_line(1'b0, 8);
        hold_line(1'b1, 1);
        idle_cycles(2 * FRAME_CLKS);
      end
    endcase
    if (v.exp_word) begin
      wait_word();
      w = rx_q.pop_front();
      check_value("rx_out.data", 32'(w.data), 32'(v.exp_data));
      check_value("rx_out.frame_err", 32'(w.frame_err), 32'(v.exp_err));
    end
    check_value("unexpected rx_out words", rx_q.size(), 0);
    check_value("tx_done count", done_cnt - done_before, done_step);
  endtask

  initial begin
    logic [7:0] rand_byte;
    arst_n    = 1'b0;
    tx_req    = '0;
    loop_mode = 1'b1;
    force_rxd = 1'b1;
    done_cnt  = 0;
    seed      = 32'he3ee_92e9;

    foreach (FIXED_BYTES[i]) begin
      add_vec(KIND_LOOP, FIXED_BYTES[i], 1'b1, 1'b1, 1'b0);
    end
    add_vec(KIND_DROP, 8'h3C, 1'b1, 1'b1, 1'b0);
    // a low stop bit is flagged, the frame after it is clean again
    add_vec(KIND_FORCE, 8'hA5, 1'b0, 1'b1, 1'b1);
    add_vec(KIND_FORCE, 8'h5A, 1'b1, 1'b1, 1'b0);
    add_vec(KIND_GLITCH, 8'h00, 1'b1, 1'b0, 1'b0);
    for (int i = 0; i < 20; i++) begin
      rand_byte = 8'($random(seed));
      add_vec(KIND_LOOP, rand_byte, 1'b1, 1'b1, 1'b0);
    end
    table_len = vec_q.size();

    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("txd", 32'(txd), 1);
    check_value("tx_done", 32'(tx_done), 0);
    check_value("rx_out.valid", 32'(rx_out.valid), 0);
    // the line stays idle a while before the first request
    idle_cycles(IDLE_CYCLES);

    foreach (vec_q[i]) begin
      run_vec(vec_q[i]);
    end

    if (uart_core_inst.uart_core_assert_inst.fail_cnt != 0) begin
      $display("%0d assertion failures were reported",
               uart_core_inst.uart_core_assert_inst.fail_cnt);
      $display("TEST FAILED");
      $fatal(1, "assertion failures");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

  // two frame periods per table entry, plus reset and the idle stretch
  initial begin
    wait (table_len != 0);
    #(longint'(table_len) * 2 * FRAME_CLKS * 10 + longint'(RST_CYCLES + IDLE_CYCLES) * 10);
    stop_with_error("timeout, the tests did not finish in time");
  end

endmodule

// ==== filelist.f ====
source/uart_cfg_pkg.sv
source/uart_frame_pkg.sv
source/uart_baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_core.sv
sim/uart_core_assert.sv
sim/uart_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the UART core and its testbench with Verilator, runs the simulation
# and decides pass or fail from the simulation log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module uart_core_tb \
  -f filelist.f \
  -o uart_core_sim > build.log 2>&1 \
  && ./obj_dir/uart_core_sim > sim.log 2>&1 \
  || echo "build or simulation ended with an error, see build.log and sim.log"

grep -qx "TEST PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

exit 0
